// ==== lsu_pipe.f ====
+incdir+include
rtl/lsu_pkg.sv
rtl/load_align.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/lsu_pipe_top.sv
dv/lsu_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: lsu_pipe

export_include_dirs:
  - include

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/load_align.sv
      - rtl/mem_stage.sv
      - rtl/wb_stage.sv
      - rtl/lsu_pipe_top.sv
  - target: test
    files:
      - dv/lsu_pipe_tb.sv

// ==== dv/lsu_pipe_tb.sv ====
`timescale 1ns/1ps

module lsu_pipe_tb;

    localparam int N_INSTR     = 35; // instructions issued over all tests
    localparam int MAX_DELAY   = 4;  // longest SRAM response wait
    localparam int STALL_CYC   = 4;
    // response wait plus issue, pulse and retire for each instruction
    localparam int CYCLE_LIMIT = 2 * (N_INSTR * (MAX_DELAY + 3) + STALL_CYC + 3);

    logic               clk = 1'b0;
    logic               resetn;
    logic               flush;
    logic               ex_valid;
    lsu_pkg::xlen_t     ex_pc;
    lsu_pkg::xlen_t     ex_alu_result;
    logic               ex_rf_we;
    lsu_pkg::reg_addr_t ex_rf_waddr;
    logic               ex_is_load;
    lsu_pkg::ld_op_e    ex_ld_op;
    logic               mem_allowin;
    logic               data_sram_data_ok;
    lsu_pkg::xlen_t     data_sram_rdata;
    logic               fwd_we;
    lsu_pkg::reg_addr_t fwd_waddr;
    lsu_pkg::xlen_t     fwd_wdata;
    logic               retire_ready;
    logic               retire_valid;
    lsu_pkg::xlen_t     retire_pc;
    logic               rf_we;
    lsu_pkg::reg_addr_t rf_waddr;
    lsu_pkg::xlen_t     rf_wdata;

    int                 cycle = 0;
    int                 errors = 0;
    int                 checks = 0;
    int                 tests_run = 0;
    int                 err_mark;
    logic [31:0]        lcg_state = 32'hf0dd;
    logic               seen_fwd_we; // forwarding seen during the data_ok pulse
    lsu_pkg::reg_addr_t seen_fwd_waddr;
    lsu_pkg::xlen_t     seen_fwd_wdata;

    // expected retire slots with the oldest first
    lsu_pkg::xlen_t     exp_pc[$];
    logic               exp_we[$];
    lsu_pkg::reg_addr_t exp_waddr[$];
    lsu_pkg::xlen_t     exp_wdata[$];
    int                 exp_due[$]; // retire cycle or -1 when not timed

    lsu_pipe_top DUT (
        .clk               (clk),
        .resetn            (resetn),
        .flush             (flush),
        .ex_valid          (ex_valid),
        .ex_pc             (ex_pc),
        .ex_alu_result     (ex_alu_result),
        .ex_rf_we          (ex_rf_we),
        .ex_rf_waddr       (ex_rf_waddr),
        .ex_is_load        (ex_is_load),
        .ex_ld_op          (ex_ld_op),
        .mem_allowin       (mem_allowin),
        .data_sram_data_ok (data_sram_data_ok),
        .data_sram_rdata   (data_sram_rdata),
        .fwd_we            (fwd_we),
        .fwd_waddr         (fwd_waddr),
        .fwd_wdata         (fwd_wdata),
        .retire_ready      (retire_ready),
        .retire_valid      (retire_valid),
        .retire_pc         (retire_pc),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata)
    );

    always #2 clk = ~clk;

    always @(negedge clk) begin
        cycle++;
        if (cycle > CYCLE_LIMIT) begin
            $display("run stopped: no progress within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected load value from lane select and fill rule
    function automatic lsu_pkg::xlen_t extend_load(lsu_pkg::xlen_t word, logic [1:0] off,
                                                   lsu_pkg::ld_op_e op);
        lsu_pkg::xlen_t b_sh;
        lsu_pkg::xlen_t h_sh;
        b_sh = word >> (8 * off);
        h_sh = word >> (16 * off[1]); // halfword ignores bit 0
        case (op)
            lsu_pkg::LD_B:  return {{24{b_sh[7]}}, b_sh[7:0]};
            lsu_pkg::LD_BU: return {24'h0, b_sh[7:0]};
            lsu_pkg::LD_H:  return {{16{h_sh[15]}}, h_sh[15:0]};
            lsu_pkg::LD_HU: return {16'h0, h_sh[15:0]};
            default:        return word;
        endcase
    endfunction

    task automatic check_word(string name, lsu_pkg::xlen_t got, lsu_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg(string name, lsu_pkg::reg_addr_t got, lsu_pkg::reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic expect_retire(lsu_pkg::xlen_t pc, logic we, lsu_pkg::reg_addr_t waddr,
                                 lsu_pkg::xlen_t wdata, int due);
        exp_pc.push_back(pc);
        exp_we.push_back(we && (waddr != 5'd0)); // x0 never written
        exp_waddr.push_back(waddr);
        exp_wdata.push_back(wdata);
        exp_due.push_back(due);
    endtask

    // retire slot monitor
    always @(posedge clk) begin
        int due;
        if (resetn && retire_valid && retire_ready) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("error at %0t: pc %h retired with nothing outstanding", $time, retire_pc);
            end else begin
                check_word("retire_pc", retire_pc, exp_pc.pop_front());
                check_bit("rf_we", rf_we, exp_we.pop_front());
                check_reg("rf_waddr", rf_waddr, exp_waddr.pop_front());
                check_word("rf_wdata", rf_wdata, exp_wdata.pop_front());
                due = exp_due.pop_front();
                if (due >= 0 && due != cycle) begin
                    errors++;
                    $display("error at %0t: retire cycle got %0d expected %0d", $time, cycle, due);
                end
            end
        end
    end

    // called and returns just after a falling edge
    task automatic issue(lsu_pkg::xlen_t pc, lsu_pkg::xlen_t alu, logic we,
                         lsu_pkg::reg_addr_t waddr, logic is_load, lsu_pkg::ld_op_e op,
                         logic timed);
        logic taken;
        int   due;
        taken = 1'b0;
        ex_valid      = 1'b1;
        ex_pc         = pc;
        ex_alu_result = alu;
        ex_rf_we      = we;
        ex_rf_waddr   = waddr;
        ex_is_load    = is_load;
        ex_ld_op      = op;
        while (!taken) begin
            @(posedge clk);
            taken = mem_allowin;
            if (!taken) begin
                @(negedge clk);
            end
        end
        due = timed ? cycle + 2 : -1; // two edges to the retire slot
        @(negedge clk);
        ex_valid = 1'b0;
        if (!is_load) begin
            expect_retire(pc, we, waddr, alu, due);
        end
    endtask

    // SRAM side answering with one data_ok pulse after an LCG delay
    task automatic answer_load(output lsu_pkg::xlen_t word);
        int unsigned wait_cyc;
        wait_cyc = 1 + (rand_word() >> 16) % MAX_DELAY;
        word = rand_word();
        repeat (wait_cyc) @(negedge clk);
        data_sram_data_ok = 1'b1;
        data_sram_rdata   = word;
        @(posedge clk);
        seen_fwd_we    = fwd_we;
        seen_fwd_waddr = fwd_waddr;
        seen_fwd_wdata = fwd_wdata;
        @(negedge clk);
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = ~word; // bus no longer carries the word
    endtask

    task automatic drain();
        @(negedge clk);
        while (exp_pc.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test();
        err_mark = errors;
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("%-20s ok", name);
        end else begin
            $display("%-20s %0d errors", name, errors - err_mark);
        end
    endtask

    task automatic stream_alu_ops();
        lsu_pkg::xlen_t alu;
        start_test();
        @(posedge clk);
        check_bit("mem_allowin", mem_allowin, 1'b1); // idle after reset
        check_bit("mem_to_wb_valid", DUT.mem_to_wb_valid, 1'b0);
        check_bit("fwd_we", fwd_we, 1'b0);
        check_bit("retire_valid", retire_valid, 1'b0);
        check_bit("rf_we", rf_we, 1'b0);
        @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            alu = rand_word();
            issue(32'h1000 + 4 * i, alu, 1'b1, 5'(i + 1), 1'b0, lsu_pkg::LD_W, 1'b1);
        end
        drain();
        finish_test("back-to-back alu");
    endtask

    task automatic sweep_load_extension();
        lsu_pkg::ld_op_e ops [5];
        lsu_pkg::xlen_t  addr;
        lsu_pkg::xlen_t  word;
        lsu_pkg::xlen_t  pc;
        start_test();
        ops = '{lsu_pkg::LD_B, lsu_pkg::LD_BU, lsu_pkg::LD_H, lsu_pkg::LD_HU, lsu_pkg::LD_W};
        pc = 32'h2000;
        foreach (ops[k]) begin
            for (int off = 0; off < 4; off++) begin
                addr = rand_word();
                addr[1:0] = 2'(off);
                issue(pc, addr, 1'b1, 5'd10, 1'b1, ops[k], 1'b0);
                answer_load(word);
                expect_retire(pc, 1'b1, 5'd10, extend_load(word, addr[1:0], ops[k]), -1);
                pc += 4;
            end
        end
        drain();
        finish_test("load extension");
    endtask

    task automatic stall_load_response();
        lsu_pkg::xlen_t addr;
        lsu_pkg::xlen_t word;
        start_test();
        retire_ready = 1'b0;
        addr = 32'h0000_8002;
        issue(32'h3000, 32'h0000_0abc, 1'b1, 5'd3, 1'b0, lsu_pkg::LD_W, 1'b0);
        issue(32'h3004, addr, 1'b1, 5'd4, 1'b1, lsu_pkg::LD_H, 1'b0);
        answer_load(word); // lands while write-back is stalled
        check_bit("fwd_we", seen_fwd_we, 1'b1);
        repeat (STALL_CYC) begin
            @(posedge clk);
            check_bit("retire_valid", retire_valid, 1'b1);
            check_word("retire_pc", retire_pc, 32'h3000);
            check_bit("rf_we", rf_we, 1'b0);
            check_bit("mem_allowin", mem_allowin, 1'b0);
        end
        expect_retire(32'h3004, 1'b1, 5'd4, extend_load(word, addr[1:0], lsu_pkg::LD_H), -1);
        @(negedge clk);
        retire_ready = 1'b1;
        drain();
        finish_test("back-pressure");
    endtask

    task automatic write_register_zero();
        start_test();
        issue(32'h4000, 32'h1234_5678, 1'b1, 5'd0, 1'b0, lsu_pkg::LD_W, 1'b0);
        drain();
        finish_test("write to x0");
    endtask

    task automatic observe_forwarding();
        lsu_pkg::xlen_t addr;
        lsu_pkg::xlen_t word;
        lsu_pkg::xlen_t exp;
        start_test();
        addr = 32'h0000_1001;
        issue(32'h5000, addr, 1'b1, 5'd7, 1'b1, lsu_pkg::LD_BU, 1'b0);
        @(posedge clk);
        check_bit("fwd_we", fwd_we, 1'b0); // load still waiting
        answer_load(word);
        exp = extend_load(word, addr[1:0], lsu_pkg::LD_BU);
        check_bit("fwd_we", seen_fwd_we, 1'b1);
        check_reg("fwd_waddr", seen_fwd_waddr, 5'd7);
        check_word("fwd_wdata", seen_fwd_wdata, exp);
        expect_retire(32'h5000, 1'b1, 5'd7, exp, -1);
        issue(32'h5004, 32'h0bad_f00d, 1'b1, 5'd9, 1'b0, lsu_pkg::LD_W, 1'b0);
        @(posedge clk);
        check_bit("fwd_we", fwd_we, 1'b1);
        check_reg("fwd_waddr", fwd_waddr, 5'd9);
        check_word("fwd_wdata", fwd_wdata, 32'h0bad_f00d);
        drain();
        finish_test("forwarding");
    endtask

    task automatic flush_waiting_load();
        lsu_pkg::xlen_t word;
        start_test();
        issue(32'h6000, 32'h0000_0004, 1'b1, 5'd12, 1'b1, lsu_pkg::LD_W, 1'b0);
        flush = 1'b1;
        @(posedge clk);
        check_bit("mem_allowin", mem_allowin, 1'b0);
        check_bit("fwd_we", fwd_we, 1'b0);
        @(negedge clk);
        flush = 1'b0;
        answer_load(word); // dropped load still gets its response
        check_bit("retire_valid", retire_valid, 1'b0);
        issue(32'h6004, 32'h0000_0777, 1'b1, 5'd13, 1'b0, lsu_pkg::LD_W, 1'b0);
        drain();
        finish_test("flush");
    endtask

    initial begin
        resetn            = 1'b0;
        flush             = 1'b0;
        ex_valid          = 1'b0;
        ex_pc             = '0;
        ex_alu_result     = '0;
        ex_rf_we          = 1'b0;
        ex_rf_waddr       = '0;
        ex_is_load        = 1'b0;
        ex_ld_op          = lsu_pkg::LD_W;
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = '0;
        retire_ready      = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        stream_alu_ops();
        sweep_load_extension();
        stall_load_response();
        write_register_zero();
        observe_forwarding();
        flush_waiting_load();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== rtl/lsu_pipe_top.sv ====
`timescale 1ns/1ps

module lsu_pipe_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                flush,
    // execute side
    input  logic                ex_valid,
    input  lsu_pkg::xlen_t      ex_pc,
    input  lsu_pkg::xlen_t      ex_alu_result,
    input  logic                ex_rf_we,
    input  lsu_pkg::reg_addr_t  ex_rf_waddr,
    input  logic                ex_is_load,
    input  lsu_pkg::ld_op_e     ex_ld_op,
    output logic                mem_allowin,
    // data SRAM response
    input  logic                data_sram_data_ok,
    input  lsu_pkg::xlen_t      data_sram_rdata,
    // forwarding to decode
    output logic                fwd_we,
    output lsu_pkg::reg_addr_t  fwd_waddr,
    output lsu_pkg::xlen_t      fwd_wdata,
    // retire slot and register write port
    input  logic                retire_ready,
    output logic                retire_valid,
    output lsu_pkg::xlen_t      retire_pc,
    output logic                rf_we,
    output lsu_pkg::reg_addr_t  rf_waddr,
    output lsu_pkg::xlen_t      rf_wdata
);

    logic               wb_allowin;
    logic               mem_to_wb_valid;
    lsu_pkg::xlen_t     mem_pc;
    logic               mem_rf_we;
    lsu_pkg::reg_addr_t mem_rf_waddr;
    lsu_pkg::xlen_t     mem_rf_wdata;

    mem_stage u_mem_stage (
        .clk               (clk),
        .resetn            (resetn),
        .flush             (flush),
        .ex_valid          (ex_valid),
        .ex_pc             (ex_pc),
        .ex_alu_result     (ex_alu_result),
        .ex_rf_we          (ex_rf_we),
        .ex_rf_waddr       (ex_rf_waddr),
        .ex_is_load        (ex_is_load),
        .ex_ld_op          (ex_ld_op),
        .mem_allowin       (mem_allowin),
        .data_sram_data_ok (data_sram_data_ok),
        .data_sram_rdata   (data_sram_rdata),
        .wb_allowin        (wb_allowin),
        .mem_to_wb_valid   (mem_to_wb_valid),
        .mem_pc            (mem_pc),
        .mem_rf_we         (mem_rf_we),
        .mem_rf_waddr      (mem_rf_waddr),
        .mem_rf_wdata      (mem_rf_wdata),
        .fwd_we            (fwd_we),
        .fwd_waddr         (fwd_waddr),
        .fwd_wdata         (fwd_wdata)
    );

    wb_stage u_wb_stage (
        .clk             (clk),
        .resetn          (resetn),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_pc          (mem_pc),
        .mem_rf_we       (mem_rf_we),
        .mem_rf_waddr    (mem_rf_waddr),
        .mem_rf_wdata    (mem_rf_wdata),
        .wb_allowin      (wb_allowin),
        .retire_ready    (retire_ready),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata)
    );

endmodule

// ==== rtl/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    input  logic                clk,
    input  logic                resetn,
    // from memory-access stage
    input  logic                mem_to_wb_valid,
    input  lsu_pkg::xlen_t      mem_pc,
    input  logic                mem_rf_we,
    input  lsu_pkg::reg_addr_t  mem_rf_waddr,
    input  lsu_pkg::xlen_t      mem_rf_wdata,
    output logic                wb_allowin,
    // retire slot and register write port
    input  logic                retire_ready,
    output logic                retire_valid,
    output lsu_pkg::xlen_t      retire_pc,
    output logic                rf_we,
    output lsu_pkg::reg_addr_t  rf_waddr,
    output lsu_pkg::xlen_t      rf_wdata
);

    logic               wb_valid;
    logic               wb_rf_we;
    lsu_pkg::xlen_t     wb_pc;
    lsu_pkg::reg_addr_t wb_rf_waddr;
    lsu_pkg::xlen_t     wb_rf_wdata;

    assign wb_allowin = ~wb_valid | retire_ready; // empty or leaving

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_pc       <= mem_pc;
            wb_rf_we    <= mem_rf_we;
            wb_rf_waddr <= mem_rf_waddr;
            wb_rf_wdata <= mem_rf_wdata;
        end
    end

    assign retire_valid = wb_valid;
    assign retire_pc    = wb_pc;

    // write only on retirement, x0 is hard-wired to zero
    assign rf_we    = wb_valid & retire_ready & wb_rf_we & (wb_rf_waddr != '0);
    assign rf_waddr = wb_rf_waddr;
    assign rf_wdata = wb_rf_wdata;

    // an offered slot stays put until taken
    a_retire_hold : assert property (
        @(posedge clk) disable iff (!resetn)
        (retire_valid && !retire_ready) |=>
            (retire_valid && $stable({retire_pc, rf_waddr, rf_wdata}))
    );

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                resetn,
    input  logic                flush,
    // from execute
    input  logic                ex_valid,
    input  lsu_pkg::xlen_t      ex_pc,
    input  lsu_pkg::xlen_t      ex_alu_result,
    input  logic                ex_rf_we,
    input  lsu_pkg::reg_addr_t  ex_rf_waddr,
    input  logic                ex_is_load,
    input  lsu_pkg::ld_op_e     ex_ld_op,
    output logic                mem_allowin,
    // data SRAM read response
    input  logic                data_sram_data_ok,
    input  lsu_pkg::xlen_t      data_sram_rdata,
    // to write-back
    input  logic                wb_allowin,
    output logic                mem_to_wb_valid,
    output lsu_pkg::xlen_t      mem_pc,
    output logic                mem_rf_we,
    output lsu_pkg::reg_addr_t  mem_rf_waddr,
    output lsu_pkg::xlen_t      mem_rf_wdata,
    // forwarding to decode
    output logic                fwd_we,
    output lsu_pkg::reg_addr_t  fwd_waddr,
    output lsu_pkg::xlen_t      fwd_wdata
);

    logic               mem_valid;
    logic               resp_wait;  // load issued and its response still owed
    logic               buf_valid;
    lsu_pkg::xlen_t     resp_buf;
    lsu_pkg::xlen_t     mem_alu_result;
    logic               mem_is_load;
    lsu_pkg::ld_op_e    mem_ld_op;
    lsu_pkg::xlen_t     resp_word;
    lsu_pkg::xlen_t     load_data;
    logic               resp_now;
    logic               ready_go;
    logic               accept;
    logic               move_on;

    assign resp_now = resp_wait & data_sram_data_ok;
    assign ready_go = ~mem_is_load | buf_valid | resp_now;

    // a flushed load still owes its response, so hold off new work until it lands
    assign mem_allowin = ~flush & ((~mem_valid & (~resp_wait | data_sram_data_ok))
                                   | (ready_go & wb_allowin));
    assign accept      = ex_valid & mem_allowin;

    assign mem_to_wb_valid = mem_valid & ready_go & ~flush;
    assign move_on         = mem_to_wb_valid & wb_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (flush) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            resp_wait <= 1'b0;
        end else if (accept) begin
            resp_wait <= ex_is_load;
        end else if (data_sram_data_ok) begin
            resp_wait <= 1'b0;
        end
    end

    // keep the response while write-back is stalled
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (move_on || flush) begin
            buf_valid <= 1'b0;
        end else if (resp_now && mem_valid) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_now && !buf_valid) begin
            resp_buf <= data_sram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_pc         <= ex_pc;
            mem_alu_result <= ex_alu_result;
            mem_rf_we      <= ex_rf_we;
            mem_rf_waddr   <= ex_rf_waddr;
            mem_is_load    <= ex_is_load;
            mem_ld_op      <= ex_ld_op;
        end
    end

    assign resp_word = buf_valid ? resp_buf : data_sram_rdata; // raw word passes through

    load_align u_load_align (
        .rdata    (resp_word),
        .byte_off (mem_alu_result[1:0]),
        .ld_op    (mem_ld_op),
        .ldata    (load_data)
    );

    assign mem_rf_wdata = mem_is_load ? load_data : mem_alu_result;

    assign fwd_we    = mem_valid & mem_rf_we & ready_go; // value final only
    assign fwd_waddr = mem_rf_waddr;
    assign fwd_wdata = mem_rf_wdata;

    // responses only arrive for a load that issued and has not been answered
    a_no_stray_resp : assert property (
        @(posedge clk) disable iff (!resetn)
        data_sram_data_ok |-> resp_wait
    );

    // a buffered word belongs to the answered load still held in the stage
    a_buf_owned : assert property (
        @(posedge clk) disable iff (!resetn)
        buf_valid |-> (mem_valid && mem_is_load && !resp_wait)
    );

    a_payload_hold : assert property (
        @(posedge clk) disable iff (!resetn)
        (mem_to_wb_valid && !wb_allowin && !flush) |=>
            $stable({mem_pc, mem_rf_we, mem_rf_waddr, mem_rf_wdata})
    );

endmodule

// ==== rtl/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  lsu_pkg::xlen_t  rdata,
    input  logic [1:0]      byte_off,
    input  lsu_pkg::ld_op_e ld_op,
    output lsu_pkg::xlen_t  ldata
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // byte lane from the low address bits
    always_comb begin
        case (byte_off)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    assign half_sel = byte_off[1] ? rdata[31:16] : rdata[15:0]; // bit 0 ignored

    always_comb begin
        case (ld_op)
            lsu_pkg::LD_B: begin
                ldata = {{(lsu_pkg::XLEN-8){byte_sel[7]}}, byte_sel};
            end
            lsu_pkg::LD_BU: begin
                ldata = {{(lsu_pkg::XLEN-8){1'b0}}, byte_sel};
            end
            lsu_pkg::LD_H: begin
                ldata = {{(lsu_pkg::XLEN-16){half_sel[15]}}, half_sel};
            end
            lsu_pkg::LD_HU: begin
                ldata = {{(lsu_pkg::XLEN-16){1'b0}}, half_sel};
            end
            default: begin
                ldata = rdata; // LD_W, whole word
            end
        endcase
    end

endmodule

// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    `include "lsu_defs.svh"

    localparam int XLEN   = 32; // data and address width
    localparam int REG_AW = 5;  // 32 architectural registers

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // load width and sign handling
    typedef enum logic [`LSU_LD_OP_W-1:0] {
        LD_B  = `LSU_LD_B,
        LD_BU = `LSU_LD_BU,
        LD_H  = `LSU_LD_H,
        LD_HU = `LSU_LD_HU,
        LD_W  = `LSU_LD_W
    } ld_op_e;

endpackage

// ==== include/lsu_defs.svh ====
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// load width and signedness, 3-bit code
`define LSU_LD_B   3'd0 // signed byte
`define LSU_LD_BU  3'd1 // unsigned byte
`define LSU_LD_H   3'd2 // signed halfword
`define LSU_LD_HU  3'd3 // unsigned halfword
`define LSU_LD_W   3'd4 // full word

`define LSU_LD_OP_W 3

`endif
